//--- compile.f
hw/vec_cfg_pkg.sv
hw/lq_pkg.sv
hw/lq_last_tracker.sv
hw/vreg_group_accum.sv
hw/commit_merge.sv
hw/mem_req_filter.sv
hw/vec_commit_unit.sv
sim/vec_commit_checker.sv
sim/tb_vec_commit_unit.sv

//--- hw/commit_merge.sv
// Commit decision and commit data selection between scalar and vector sources
`default_nettype none

module commit_merge
   import vec_cfg_pkg::*;
(
   input  logic    i_rf_wr,
   input  xdata_t  i_rf_wrdata,
   input  logic    i_vec_nonstore_commit,
   input  logic    i_head_last,
   input  vgroup_t i_group_nxt,
   input  gmask_t  i_mask_nxt,
   input  fflags_t i_fflags_nxt,
   output logic    o_commit_valid,
   output vgroup_t o_commit_data,
   output gmask_t  o_commit_mask,
   output fflags_t o_commit_fflags
);

   // Vector commit only counts once the head entry is last
   assign o_commit_valid = i_rf_wr ||
                           (i_vec_nonstore_commit && i_head_last);

   // Upper part only ever comes from the vector group
   assign o_commit_data[GROUP_W-1:XLEN] =
      {(GROUP_W-XLEN){i_vec_nonstore_commit}} & i_group_nxt[GROUP_W-1:XLEN];

   assign o_commit_data[XLEN-1:0] =
      ({XLEN{i_vec_nonstore_commit}} & i_group_nxt[XLEN-1:0]) |
      ({XLEN{i_rf_wr}}               & i_rf_wrdata);

   assign o_commit_fflags = {FFLAGS_W{i_vec_nonstore_commit}} & i_fflags_nxt;

   assign o_commit_mask = i_mask_nxt;

endmodule

`default_nettype wire

//--- hw/lq_last_tracker.sv
// Load-queue last flags, commit read pointer and last-flag lookups
`default_nettype none

module lq_last_tracker
   import lq_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_reset,
   input  logic   i_lq_alloc,
   input  lqid_t  i_lq_alloc_id,
   input  logic   i_lq_done,
   input  logic   i_lq_commit,
   input  reqid_t i_req_id,
   output logic   o_head_last,
   output logic   o_req_is_last
);

   logic [LQ_DEPTH-1:0] lq_last;
   lqid_t               lq_rd_ptr;
   lqid_t               alloc_id_r;

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lq_last    <= '0;
         lq_rd_ptr  <= '0;
         alloc_id_r <= '0;
      end else begin
         if (i_lq_commit) begin
            lq_rd_ptr <= lq_rd_ptr + 1'b1;
         end

         // Done at allocation marks the new entry directly
         if (i_lq_alloc) begin
            lq_last[i_lq_alloc_id] <= i_lq_done;
            alloc_id_r             <= i_lq_alloc_id;
         end else if (i_lq_done) begin
            // Late done goes to the most recent allocation
            lq_last[alloc_id_r] <= 1'b1;
         end
      end
   end

   assign o_head_last = lq_last[lq_rd_ptr];

   // Low request id bits name the queue entry
   assign o_req_is_last = lq_last[i_req_id[LQID_W-1:0]];

endmodule

`default_nettype wire

//--- hw/lq_pkg.sv
// Load-queue and memory-request widths and types
`default_nettype none

package lq_pkg;

   localparam int LQ_DEPTH = 8;
   localparam int LQID_W   = $clog2(LQ_DEPTH);

   // Request id carries the lqid in its low bits
   localparam int REQID_W  = 5;

   localparam int BYTEN_W  = 4;

   typedef logic [LQID_W-1:0]  lqid_t;
   typedef logic [REQID_W-1:0] reqid_t;
   typedef logic [BYTEN_W-1:0] byten_t;

endpackage

`default_nettype wire

//--- hw/mem_req_filter.sv
// Memory request filter for empty loads with local response and last qualification
`default_nettype none

module mem_req_filter
   import lq_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_reset,
   input  logic   i_req,
   input  logic   i_req_load,
   input  byten_t i_req_byten,
   input  reqid_t i_req_id,
   input  logic   i_req_last_raw,
   input  logic   i_req_is_last,
   input  logic   i_data_req_rtr,
   output logic   o_data_req,
   output logic   o_mem_last,
   output logic   o_rd_data_vld_local,
   output reqid_t o_rd_data_resp_id_local
);

   logic empty_load;

   // Load with nothing enabled needs no memory access
   assign empty_load = i_req_load && ~|i_req_byten;

   assign o_data_req = i_req && !empty_load;

   assign o_mem_last = i_req_last_raw && i_req_is_last;

   // Local answer one cycle after the memory would have accepted it
   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         o_rd_data_vld_local <= 1'b0;
      end else begin
         o_rd_data_vld_local <= i_req && i_data_req_rtr && empty_load;
      end
   end

   always_ff @(posedge i_clk) begin
      o_rd_data_resp_id_local <= i_req_id;
   end

endmodule

`default_nettype wire

//--- hw/vec_cfg_pkg.sv
// Vector datapath widths and types for the commit back end
`default_nettype none

package vec_cfg_pkg;

   // Register and group geometry
   localparam int VLEN     = 32;
   localparam int LMUL_MAX = 8;
   localparam int XLEN     = 64;
   localparam int GROUP_W  = VLEN * LMUL_MAX;

   // Exception flags as in fcsr
   localparam int FFLAGS_W = 5;

   // vl must be able to hold VLEN itself
   localparam int VL_W     = $clog2(VLEN + 1);
   localparam int LCNT_W   = $clog2(LMUL_MAX);

   typedef logic [VLEN-1:0]     vreg_t;
   typedef logic [GROUP_W-1:0]  vgroup_t;
   typedef logic [XLEN-1:0]     xdata_t;
   typedef logic [LMUL_MAX-1:0] gmask_t;
   typedef logic [FFLAGS_W-1:0] fflags_t;
   typedef logic [VL_W-1:0]     vl_t;
   typedef logic [LCNT_W-1:0]   lmul_cnt_t;

endpackage

`default_nettype wire

//--- hw/vec_commit_unit.sv
// Vector commit and memory request back end top level
`default_nettype none

module vec_commit_unit
   import vec_cfg_pkg::*, lq_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,

   // Load queue events
   input  logic    i_lq_alloc,
   input  lqid_t   i_lq_alloc_id,
   input  logic    i_lq_done,
   input  logic    i_lq_commit,

   // Writebacks
   input  logic    i_rf_wr,
   input  xdata_t  i_rf_wrdata,
   input  logic    i_vrf_wr,
   input  vreg_t   i_vrf_wrdata,
   input  fflags_t i_vrf_wrexc,
   input  logic    i_vec_nonstore_commit,
   input  vl_t     i_csr_vl,

   // Commit
   output logic    o_commit_valid,
   output vgroup_t o_commit_data,
   output gmask_t  o_commit_mask,
   output fflags_t o_commit_fflags,

   // Memory request side
   input  logic    i_req,
   input  logic    i_req_load,
   input  byten_t  i_req_byten,
   input  reqid_t  i_req_id,
   input  logic    i_req_last_raw,
   input  logic    i_data_req_rtr,
   output logic    o_data_req,
   output logic    o_mem_last,
   output logic    o_rd_data_vld_local,
   output reqid_t  o_rd_data_resp_id_local
);

   logic    head_last;
   logic    req_is_last;
   vgroup_t group_nxt;
   gmask_t  mask_nxt;
   fflags_t fflags_nxt;

   lq_last_tracker u_lq_last_tracker (
      .i_clk         (i_clk),
      .i_reset       (i_reset),
      .i_lq_alloc    (i_lq_alloc),
      .i_lq_alloc_id (i_lq_alloc_id),
      .i_lq_done     (i_lq_done),
      .i_lq_commit   (i_lq_commit),
      .i_req_id      (i_req_id),
      .o_head_last   (head_last),
      .o_req_is_last (req_is_last)
   );

   // Commit clears the group being built
   vreg_group_accum u_vreg_group_accum (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_vrf_wr     (i_vrf_wr),
      .i_vrf_wrdata (i_vrf_wrdata),
      .i_vrf_wrexc  (i_vrf_wrexc),
      .i_csr_vl     (i_csr_vl),
      .i_clear      (o_commit_valid),
      .o_group_nxt  (group_nxt),
      .o_mask_nxt   (mask_nxt),
      .o_fflags_nxt (fflags_nxt)
   );

   commit_merge u_commit_merge (
      .i_rf_wr               (i_rf_wr),
      .i_rf_wrdata           (i_rf_wrdata),
      .i_vec_nonstore_commit (i_vec_nonstore_commit),
      .i_head_last           (head_last),
      .i_group_nxt           (group_nxt),
      .i_mask_nxt            (mask_nxt),
      .i_fflags_nxt          (fflags_nxt),
      .o_commit_valid        (o_commit_valid),
      .o_commit_data         (o_commit_data),
      .o_commit_mask         (o_commit_mask),
      .o_commit_fflags       (o_commit_fflags)
   );

   mem_req_filter u_mem_req_filter (
      .i_clk                   (i_clk),
      .i_reset                 (i_reset),
      .i_req                   (i_req),
      .i_req_load              (i_req_load),
      .i_req_byten             (i_req_byten),
      .i_req_id                (i_req_id),
      .i_req_last_raw          (i_req_last_raw),
      .i_req_is_last           (req_is_last),
      .i_data_req_rtr          (i_data_req_rtr),
      .o_data_req              (o_data_req),
      .o_mem_last              (o_mem_last),
      .o_rd_data_vld_local     (o_rd_data_vld_local),
      .o_rd_data_resp_id_local (o_rd_data_resp_id_local)
   );

endmodule

`default_nettype wire

//--- hw/vreg_group_accum.sv
// Register-group writeback accumulator building the wide commit word
`default_nettype none

module vreg_group_accum
   import vec_cfg_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  logic    i_vrf_wr,
   input  vreg_t   i_vrf_wrdata,
   input  fflags_t i_vrf_wrexc,
   input  vl_t     i_csr_vl,
   input  logic    i_clear,
   output vgroup_t o_group_nxt,
   output gmask_t  o_mask_nxt,
   output fflags_t o_fflags_nxt
);

   vgroup_t   group_reg;
   gmask_t    mask_reg;
   fflags_t   fflags_reg;
   lmul_cnt_t lmul_cnt;

   // Current beat merged over the held group
   always_comb begin
      o_group_nxt  = group_reg;
      o_mask_nxt   = mask_reg;
      o_fflags_nxt = fflags_reg;

      o_group_nxt[VLEN*lmul_cnt +: VLEN] = i_vrf_wrdata;
      o_mask_nxt[lmul_cnt]               = |i_csr_vl;
      o_fflags_nxt                       = fflags_reg | i_vrf_wrexc;
   end

   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         group_reg  <= '0;
         mask_reg   <= '0;
         fflags_reg <= '0;
      end else begin
         if (i_clear) begin
            group_reg  <= '0;
            mask_reg   <= '0;
            fflags_reg <= '0;
         end else if (i_vrf_wr) begin
            group_reg  <= o_group_nxt;
            mask_reg   <= o_mask_nxt;
            fflags_reg <= o_fflags_nxt;
         end
      end
   end

   // Beat index wraps after LMUL_MAX writes
   always_ff @(posedge i_clk, posedge i_reset) begin
      if (i_reset) begin
         lmul_cnt <= '0;
      end else begin
         if (i_clear) begin
            lmul_cnt <= '0;
         end else if (i_vrf_wr) begin
            lmul_cnt <= lmul_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vec_commit_unit \
   -f compile.f -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "NO ERRORS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- sim/tb_vec_commit_unit.sv
// Testbench for the vector commit unit with LFSR stimulus against a reference model
`default_nettype none

module tb_vec_commit_unit
   import vec_cfg_pkg::*, lq_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int IDLE_TIMEOUT = 8;

   logic i_clk, i_reset, i_lq_alloc, i_lq_done, i_lq_commit;
   lqid_t i_lq_alloc_id;
   logic i_rf_wr, i_vrf_wr, i_vec_nonstore_commit;
   xdata_t i_rf_wrdata;
   vreg_t i_vrf_wrdata;
   fflags_t i_vrf_wrexc, o_commit_fflags;
   vl_t i_csr_vl;
   logic o_commit_valid;
   vgroup_t o_commit_data;
   gmask_t o_commit_mask;
   logic i_req, i_req_load, i_req_last_raw, i_data_req_rtr;
   byten_t i_req_byten;
   reqid_t i_req_id, o_rd_data_resp_id_local;
   logic o_data_req, o_mem_last, o_rd_data_vld_local;

   logic [15:0] lfsr;
   int n_checks, n_errors, n_tests;
   bit timed_out;

   // Reference model state
   logic [LQ_DEPTH-1:0] m_last;
   lqid_t m_rd_ptr, m_alloc_id;
   vreg_t m_slot [LMUL_MAX];
   gmask_t m_mask;
   fflags_t m_fflags;
   int m_cnt;
   logic exp_vld;
   reqid_t exp_id;

   vec_commit_unit DUT (.*);

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD/2) i_clk = ~i_clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic take_bit();
      logic fb;
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[62:0], take_bit()};
      end
      return v;
   endfunction

   function automatic vl_t random_vl();
      if (take_bits(2) == 0) begin
         return '0;
      end
      return vl_t'(take_bits(5) + 1);
   endfunction

   task automatic compare_group(input string name, input vgroup_t exp, input vgroup_t act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic compare_mask(input string name, input gmask_t exp, input gmask_t act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic compare_fflags(input string name, input fflags_t exp, input fflags_t act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic compare_reqid(input string name, input reqid_t exp, input reqid_t act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      n_checks++;
      if (exp !== act) begin
         n_errors++;
         $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic drive_idle();
      i_lq_alloc = 1'b0;
      i_lq_alloc_id = '0;
      i_lq_done = 1'b0;
      i_lq_commit = 1'b0;
      i_rf_wr = 1'b0;
      i_rf_wrdata = '0;
      i_vrf_wr = 1'b0;
      i_vrf_wrdata = '0;
      i_vrf_wrexc = '0;
      i_vec_nonstore_commit = 1'b0;
      i_csr_vl = '0;
      i_req = 1'b0;
      i_req_load = 1'b0;
      i_req_byten = '0;
      i_req_id = '0;
      i_req_last_raw = 1'b0;
      i_data_req_rtr = 1'b0;
   endtask

   task automatic clear_accum();
      for (int k = 0; k < LMUL_MAX; k++) begin
         m_slot[k] = '0;
      end
      m_mask = '0;
      m_fflags = '0;
      m_cnt = 0;
   endtask

   // Registered outputs hold the previous cycle's result at the falling edge
   task automatic begin_cycle();
      @(negedge i_clk);
      compare_bit("o_rd_data_vld_local", exp_vld, o_rd_data_vld_local);
      if (exp_vld) begin
         compare_reqid("o_rd_data_resp_id_local", exp_id, o_rd_data_resp_id_local);
      end
      drive_idle();
   endtask

   task automatic end_cycle();
      vgroup_t e_data;
      gmask_t e_mask;
      logic e_valid;
      logic empty;
      #(CLK_PERIOD/4);
      e_valid = i_rf_wr || (i_vec_nonstore_commit && m_last[m_rd_ptr]);
      e_data = '0;
      if (i_vec_nonstore_commit) begin
         for (int k = 0; k < LMUL_MAX; k++) begin
            e_data[k*VLEN +: VLEN] = (k == m_cnt) ? i_vrf_wrdata : m_slot[k];
         end
      end
      if (i_rf_wr) begin
         e_data[XLEN-1:0] = e_data[XLEN-1:0] | i_rf_wrdata;
      end
      e_mask = m_mask;
      e_mask[m_cnt] = (i_csr_vl != '0);
      empty = i_req_load && (i_req_byten == '0);
      compare_bit("o_commit_valid", e_valid, o_commit_valid);
      compare_group("o_commit_data", e_data, o_commit_data);
      compare_mask("o_commit_mask", e_mask, o_commit_mask);
      compare_fflags("o_commit_fflags",
                     i_vec_nonstore_commit ? (m_fflags | i_vrf_wrexc) : '0, o_commit_fflags);
      compare_bit("o_data_req", i_req && !empty, o_data_req);
      compare_bit("o_mem_last", i_req_last_raw && m_last[i_req_id[LQID_W-1:0]], o_mem_last);
      // State the model expects after the coming rising edge
      if (i_lq_commit) begin
         m_rd_ptr = lqid_t'(m_rd_ptr + 1);
      end
      if (i_lq_alloc) begin
         m_last[i_lq_alloc_id] = i_lq_done;
         m_alloc_id = i_lq_alloc_id;
      end else if (i_lq_done) begin
         m_last[m_alloc_id] = 1'b1;
      end
      if (e_valid) begin
         clear_accum();
      end else if (i_vrf_wr) begin
         m_slot[m_cnt] = i_vrf_wrdata;
         m_mask = e_mask;
         m_fflags = m_fflags | i_vrf_wrexc;
         m_cnt = (m_cnt + 1) % LMUL_MAX;
      end
      exp_vld = i_req && i_data_req_rtr && empty;
      exp_id = i_req_id;
   endtask

   task automatic report_test(input string name, input int err_before);
      n_tests++;
      if (n_errors == err_before) begin
         $display("test %s passed", name);
      end else begin
         $display("test %s failed with %0d errors", name, n_errors - err_before);
      end
   endtask

   task automatic wait_idle_after_reset(output bit expired);
      int n;
      n = 0;
      while ((o_commit_valid !== 1'b0 || o_rd_data_vld_local !== 1'b0) && n < IDLE_TIMEOUT) begin
         @(negedge i_clk);
         n++;
      end
      expired = (o_commit_valid !== 1'b0 || o_rd_data_vld_local !== 1'b0);
   endtask

   task automatic vector_beat(input logic last);
      i_vrf_wr = 1'b1;
      i_vrf_wrdata = vreg_t'(take_bits(VLEN));
      i_vrf_wrexc = fflags_t'(take_bits(FFLAGS_W));
      i_csr_vl = random_vl();
      i_vec_nonstore_commit = last;
   endtask

   // Allocate at the head, optionally mark done, write 1 to 8 beats, then retire
   task automatic run_group(input bit mark_done);
      int n;
      begin_cycle();
      i_lq_alloc = 1'b1;
      i_lq_alloc_id = m_rd_ptr;
      end_cycle();
      if (mark_done) begin
         begin_cycle();
         i_lq_done = 1'b1;
         end_cycle();
      end
      n = int'(take_bits(3)) + 1;
      for (int b = 0; b < n; b++) begin
         begin_cycle();
         vector_beat(b == n - 1);
         end_cycle();
      end
      begin_cycle();
      i_lq_commit = 1'b1;
      end_cycle();
   endtask

   task automatic reset_values();
      int e0;
      e0 = n_errors;
      begin_cycle();
      end_cycle();
      compare_bit("o_commit_valid", 1'b0, o_commit_valid);
      compare_bit("o_data_req", 1'b0, o_data_req);
      compare_bit("o_rd_data_vld_local", 1'b0, o_rd_data_vld_local);
      compare_mask("o_commit_mask", '0, o_commit_mask);
      compare_group("o_commit_data", '0, o_commit_data);
      report_test("reset_values", e0);
   endtask

   task automatic scalar_commits();
      int e0;
      int nb;
      e0 = n_errors;
      repeat (4) begin
         nb = int'(take_bits(2));
         repeat (nb) begin
            begin_cycle();
            vector_beat(1'b0);
            end_cycle();
         end
         begin_cycle();
         i_rf_wr = 1'b1;
         i_rf_wrdata = xdata_t'(take_bits(XLEN));
         i_csr_vl = random_vl();
         end_cycle();
      end
      report_test("scalar_commit", e0);
   endtask

   task automatic request_filter();
      int e0;
      logic hold, r_req, r_load, r_last;
      byten_t r_byten;
      reqid_t r_id;
      e0 = n_errors;
      hold = 1'b0;
      repeat (200) begin
         begin_cycle();
         // Unaccepted request stays on the bus
         if (!hold) begin
            r_req = take_bit();
            r_load = take_bit();
            r_byten = (take_bits(2) == 0) ? '0 : byten_t'(take_bits(BYTEN_W));
            r_id = reqid_t'(take_bits(REQID_W));
            r_last = take_bit();
         end
         i_req = r_req;
         i_req_load = r_load;
         i_req_byten = r_byten;
         i_req_id = r_id;
         i_req_last_raw = r_last;
         i_data_req_rtr = take_bit();
         end_cycle();
         hold = r_req && !i_data_req_rtr;
      end
      begin_cycle();
      end_cycle();
      report_test("request_filter", e0);
   endtask

   task automatic mem_last_qualify();
      int e0;
      e0 = n_errors;
      for (int e = 0; e < LQ_DEPTH; e++) begin
         begin_cycle();
         i_lq_alloc = 1'b1;
         i_lq_alloc_id = lqid_t'(e);
         i_lq_done = take_bit();
         end_cycle();
      end
      repeat (24) begin
         begin_cycle();
         i_req_id = reqid_t'(take_bits(REQID_W));
         i_req_last_raw = take_bit();
         end_cycle();
      end
      report_test("mem_last", e0);
   endtask

   initial begin
      lfsr = 16'd30;
      n_checks = 0;
      n_errors = 0;
      n_tests = 0;
      m_last = '0;
      m_rd_ptr = '0;
      m_alloc_id = '0;
      exp_vld = 1'b0;
      exp_id = '0;
      clear_accum();
      drive_idle();
      i_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;
      wait_idle_after_reset(timed_out);
      if (timed_out) begin
         $display("timeout: commit or local response still active after reset");
         $display("ERRORS FOUND");
      end else begin
         reset_values();
         scalar_commits();
         group_commits();
         request_filter();
         mem_last_qualify();
         n_errors += int'(DUT.u_checker.assert_fails);
         $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
         if (n_errors == 0) begin
            $display("NO ERRORS");
         end else begin
            $display("ERRORS FOUND");
         end
      end
      $finish;
   end

   // Committed groups, then groups whose head never turns last
   task automatic group_commits();
      int e0;
      e0 = n_errors;
      repeat (4) run_group(1'b1);
      report_test("vector_group_commit", e0);
      e0 = n_errors;
      repeat (2) run_group(1'b0);
      run_group(1'b1);
      report_test("head_not_last", e0);
   endtask

endmodule

`default_nettype wire

//--- sim/vec_commit_checker.sv
// Concurrent checks on memory request filtering and commit flag gating
`default_nettype none

module vec_commit_checker
   import vec_cfg_pkg::*, lq_pkg::*;
(
   input logic    i_clk,
   input logic    i_reset,
   input logic    i_req,
   input logic    i_req_load,
   input byten_t  i_req_byten,
   input logic    i_data_req_rtr,
   input logic    i_vec_nonstore_commit,
   input logic    o_data_req,
   input logic    o_rd_data_vld_local,
   input fflags_t o_commit_fflags
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned assert_fails = 0;

   a_no_empty_load_req: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_req_load && i_req_byten == '0) |-> !o_data_req)
   else begin
      assert_fails++;
      $error("memory request issued for a load with no byte enabled");
   end

   // Accepted empty load is answered locally on the next cycle
   a_local_resp: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_req && i_data_req_rtr && i_req_load && i_req_byten == '0) |=> o_rd_data_vld_local)
   else begin
      assert_fails++;
      $error("no local response one cycle after an accepted empty load");
   end

   a_fflags_gated: assert property (@(posedge i_clk) disable iff (i_reset)
      !i_vec_nonstore_commit |-> (o_commit_fflags == '0))
   else begin
      assert_fails++;
      $error("commit flags nonzero without a vector commit");
   end

endmodule

bind vec_commit_unit vec_commit_checker u_checker (
   .i_clk                 (i_clk),
   .i_reset               (i_reset),
   .i_req                 (i_req),
   .i_req_load            (i_req_load),
   .i_req_byten           (i_req_byten),
   .i_data_req_rtr        (i_data_req_rtr),
   .i_vec_nonstore_commit (i_vec_nonstore_commit),
   .o_data_req            (o_data_req),
   .o_rd_data_vld_local   (o_rd_data_vld_local),
   .o_commit_fflags       (o_commit_fflags)
);

`default_nettype wire
